//--- dma_cmd_gen.f
logic/dma_cmd_pkg.sv
logic/dma_job_if.sv
logic/dma_split_if.sv
logic/dma_cmd_fetch.sv
logic/dma_len_calc.sv
logic/dma_cmd_emit.sv
logic/dma_cmd_top.sv
verification/dma_cmd_tb.sv

//--- Bender.yml
package:
  name: dma_cmd_gen

sources:
  - logic/dma_cmd_pkg.sv
  - logic/dma_job_if.sv
  - logic/dma_split_if.sv
  - logic/dma_cmd_fetch.sv
  - logic/dma_len_calc.sv
  - logic/dma_cmd_emit.sv
  - logic/dma_cmd_top.sv
  - target: test
    files:
      - verification/dma_cmd_tb.sv

//--- verification/dma_cmd_tb.sv
`timescale 1ns/1ns

module dma_cmd_tb
  import dma_cmd_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 2000;

  logic                pcie_user_clk = 1'b0;
  logic                pcie_user_rst_n;
  logic                dma_cmd_empty_n;
  dma_cmd_word_t       dma_cmd_rd_data;
  logic                dma_cmd_rd_en;
  logic [SLOT_TAG_W:0] hcmd_prp_rd_addr;
  prp_word_t           hcmd_prp_rd_data;
  logic                dev_rx_cmd_wr_en;
  logic                dev_rx_cmd_full_n;
  logic                dev_tx_cmd_wr_en;
  logic                dev_tx_cmd_full_n;
  dev_cmd_word_t       dev_cmd_wr_data;
  logic                pcie_cmd_wr_en;
  pcie_cmd_word_t      pcie_cmd_wr_data;
  logic                pcie_cmd_full_n;

  dma_cmd_word_t  cmd_q[$];
  prp_word_t      prp_mem [2**(SLOT_TAG_W+1)];
  dev_cmd_word_t  rx_q[$];
  dev_cmd_word_t  tx_q[$];
  pcie_cmd_word_t pcie_q[$];
  dev_cmd_word_t  exp_rx[$];
  dev_cmd_word_t  exp_tx[$];
  pcie_cmd_word_t exp_pcie[$];
  string          cur_test;
  int             pops;
  int             pops_at_start;

  dma_cmd_top DUT (.*);

  always #(CLK_PERIOD/2) pcie_user_clk = ~pcie_user_clk;

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_dev_word(dev_cmd_word_t expected, dev_cmd_word_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED %s: dev word expected %h, actual %h", cur_test, expected,
                          actual));
    end
  endtask

  task automatic check_pcie_word(pcie_cmd_word_t expected, pcie_cmd_word_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED %s: pcie word expected %h, actual %h", cur_test, expected,
                          actual));
    end
  endtask

  task automatic check_count(string what, int expected, int actual);
    if (expected != actual) begin
      abort_run($sformatf("FAILED %s: %s expected %0d, actual %0d", cur_test, what, expected,
                          actual));
    end
  endtask

  function automatic host_addr_t rand_host();
    return host_addr_t'({$urandom, $urandom});
  endfunction

  function automatic void refresh_cmd_fifo();
    dma_cmd_empty_n = (cmd_q.size() >= 2); // a whole pair
    dma_cmd_rd_data = (cmd_q.size() > 0) ? cmd_q[0] : '0;
  endfunction

  task automatic step();
    @(posedge pcie_user_clk);
    #2;
  endtask

  // command fifo pops, prp table answers one cycle after the address
  always begin : input_models
    logic                do_pop;
    logic [SLOT_TAG_W:0] prp_addr;
    @(negedge pcie_user_clk);
    do_pop   = dma_cmd_rd_en;
    prp_addr = hcmd_prp_rd_addr;
    step();
    if (do_pop && cmd_q.size() == 0) begin
      abort_run("the command FIFO was popped while empty");
    end else if (do_pop) begin
      void'(cmd_q.pop_front());
      pops++;
    end
    hcmd_prp_rd_data = prp_mem[prp_addr];
    refresh_cmd_fifo();
  end

  always @(negedge pcie_user_clk) begin
    if ((dev_rx_cmd_wr_en && !dev_rx_cmd_full_n) || (dev_tx_cmd_wr_en && !dev_tx_cmd_full_n) ||
        (pcie_cmd_wr_en && !pcie_cmd_full_n)) begin
      abort_run("a FIFO was written while its full_n was low");
    end
    if (dev_rx_cmd_wr_en) rx_q.push_back(dev_cmd_wr_data);
    if (dev_tx_cmd_wr_en) tx_q.push_back(dev_cmd_wr_data);
    if (pcie_cmd_wr_en) pcie_q.push_back(pcie_cmd_wr_data);
  end

  initial begin : watchdog
    #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    abort_run("watchdog expired: the DUT stopped producing command words");
  end

  // queues one command and the words expected from it
  task automatic issue_cmd(logic cmd_type, logic dir, slot_tag_t slot, logic auto_cpl,
                           dev_addr_t dev_addr, dw_len_t dev_len, page_idx_t page_idx,
                           host_addr_t prp1, host_addr_t prp2);
    int unsigned   sum;
    int unsigned   o;
    dw_len_t       len1;
    dw_len_t       len2;
    logic          second;
    host_addr_t    addr1;
    host_addr_t    addr2;
    dev_addr_t     base;
    dev_cmd_word_t words[$];
    if (!cmd_type) begin
      prp_mem[{slot, 1'b0}] = {8'($urandom), prp1}; // upper bits are junk
      prp_mem[{slot, 1'b1}] = {8'($urandom), prp2};
    end
    cmd_q.push_back({3'b000, cmd_type, dir, slot, dev_len, dev_addr});
    cmd_q.push_back({auto_cpl, page_idx, cmd_type ? prp1 : rand_host()});
    refresh_cmd_fifo();
    if (cmd_type) begin
      len1   = dev_len;
      len2   = '0;
      second = 1'b0;
      addr1  = prp1;
      addr2  = '0;
      base   = dev_addr;
    end else begin
      sum    = page_idx * PAGE_DW + 32'(prp1 % PAGE_DW);
      o      = sum % PAGE_DW;
      len1   = dw_len_t'(PAGE_DW - o);
      len2   = dw_len_t'(o);
      second = (o != 0);
      addr1  = (sum / PAGE_DW == 0) ? prp1 : prp2;
      addr1  = addr1 - addr1 % PAGE_DW + o;
      addr2  = prp2 - prp2 % PAGE_DW;
      base   = dev_addr - dev_addr % PAGE_DW;
    end
    words.push_back({6'b0, auto_cpl, cmd_type, !second, slot, len1});
    words.push_back(base);
    if (second) begin
      words.push_back({6'b0, auto_cpl, cmd_type, 1'b1, slot, len2});
      words.push_back(dev_addr_t'(base + len1));
    end
    foreach (words[i]) begin
      if (dir) exp_tx.push_back(words[i]);
      else exp_rx.push_back(words[i]);
    end
    exp_pcie.push_back(pcie_cmd_word_t'({auto_cpl, cmd_type, dir, second, slot}));
    exp_pcie.push_back(pcie_cmd_word_t'({len1, len2}));
    exp_pcie.push_back(addr1);
    exp_pcie.push_back(addr2);
  endtask

  task automatic start_test(string name);
    cur_test      = name;
    pops_at_start = pops;
    step();
  endtask

  task automatic finish_test(int n_cmds);
    while (rx_q.size() < exp_rx.size() || tx_q.size() < exp_tx.size() ||
           pcie_q.size() < exp_pcie.size()) begin
      @(posedge pcie_user_clk);
    end
    check_count("rx word count", exp_rx.size(), rx_q.size());
    check_count("tx word count", exp_tx.size(), tx_q.size());
    check_count("pcie word count", exp_pcie.size(), pcie_q.size());
    foreach (exp_rx[i]) check_dev_word(exp_rx[i], rx_q[i]);
    foreach (exp_tx[i]) check_dev_word(exp_tx[i], tx_q[i]);
    foreach (exp_pcie[i]) check_pcie_word(exp_pcie[i], pcie_q[i]);
    check_count("command FIFO pops", 2 * n_cmds, pops - pops_at_start);
    rx_q.delete();
    tx_q.delete();
    pcie_q.delete();
    exp_rx.delete();
    exp_tx.delete();
    exp_pcie.delete();
  endtask

  task automatic test_direct_rx();
    start_test("direct_rx");
    issue_cmd(1'b1, 1'b0, 10'd3, 1'b1, dev_addr_t'($urandom), 11'd200, 9'd0, rand_host(), '0);
    finish_test(1);
  endtask

  task automatic test_prp_one_page();
    start_test("prp_one_page");
    issue_cmd(1'b0, 1'b1, 10'd17, 1'b0, dev_addr_t'($urandom), dw_len_t'($urandom), 9'd0,
              rand_host() & ~host_addr_t'(PAGE_DW - 1), rand_host());
    finish_test(1);
  endtask

  task automatic test_prp_split();
    host_addr_t off;
    off = host_addr_t'($urandom_range(PAGE_DW - 1, 1));
    start_test("prp_split");
    issue_cmd(1'b0, 1'b0, 10'd42, 1'b1, dev_addr_t'($urandom), '0, 9'd0,
              (rand_host() & ~host_addr_t'(PAGE_DW - 1)) | off, rand_host());
    finish_test(1);
  endtask

  task automatic test_back_pressure();
    start_test("back_pressure");
    pcie_cmd_full_n = 1'b0;
    issue_cmd(1'b0, 1'b1, 10'd99, 1'b0, dev_addr_t'($urandom), '0, 9'd0, rand_host(),
              rand_host());
    repeat ($urandom_range(80, 10)) step();
    pcie_cmd_full_n   = 1'b1;
    dev_rx_cmd_full_n = 1'b0;
    issue_cmd(1'b1, 1'b0, 10'd100, 1'b1, dev_addr_t'($urandom),
              dw_len_t'($urandom_range(PAGE_DW, 1)), 9'd0, rand_host(), '0);
    repeat ($urandom_range(80, 10)) step();
    dev_rx_cmd_full_n = 1'b1;
    finish_test(2);
  endtask

  task automatic test_random_stream();
    logic       cmd_type;
    page_idx_t  page_idx;
    host_addr_t prp1;
    start_test("random_stream");
    for (int i = 0; i < 8; i++) begin
      cmd_type = 1'($urandom_range(1, 0));
      page_idx = cmd_type ? page_idx_t'($urandom) : page_idx_t'($urandom_range(1, 0));
      prp1     = rand_host();
      if (!cmd_type && page_idx == 1) prp1 = prp1 & ~host_addr_t'(PAGE_DW - 1); // no list
      issue_cmd(cmd_type, 1'($urandom_range(1, 0)), slot_tag_t'(200 + 37 * i),
                1'($urandom_range(1, 0)), dev_addr_t'($urandom),
                dw_len_t'($urandom_range(PAGE_DW, 1)), page_idx, prp1, rand_host());
    end
    finish_test(8);
  endtask

  initial begin
    void'($urandom(55));
    pcie_user_rst_n   = 1'b0;
    dma_cmd_empty_n   = 1'b0;
    dma_cmd_rd_data   = '0;
    hcmd_prp_rd_data  = '0;
    dev_rx_cmd_full_n = 1'b1;
    dev_tx_cmd_full_n = 1'b1;
    pcie_cmd_full_n   = 1'b1;
    pops              = 0;
    foreach (prp_mem[i]) prp_mem[i] = (prp_word_t'(i) << 24) ^ prp_word_t'(i * 7 + 1);
    repeat (RESET_CYCLES) @(posedge pcie_user_clk);
    #2 pcie_user_rst_n = 1'b1;
    test_direct_rx();
    test_prp_one_page();
    test_prp_split();
    test_back_pressure();
    test_random_stream();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- logic/dma_cmd_top.sv
`timescale 1ns/1ns

module dma_cmd_top
  import dma_cmd_pkg::*;
(
  input  logic                pcie_user_clk,
  input  logic                pcie_user_rst_n,

  input  logic                dma_cmd_empty_n,
  input  dma_cmd_word_t       dma_cmd_rd_data,
  output logic                dma_cmd_rd_en,

  output logic [SLOT_TAG_W:0] hcmd_prp_rd_addr,
  input  prp_word_t           hcmd_prp_rd_data,

  output logic                dev_rx_cmd_wr_en,
  input  logic                dev_rx_cmd_full_n,
  output logic                dev_tx_cmd_wr_en,
  input  logic                dev_tx_cmd_full_n,
  output dev_cmd_word_t       dev_cmd_wr_data,   // shared by rx and tx

  output logic                pcie_cmd_wr_en,
  output pcie_cmd_word_t      pcie_cmd_wr_data,
  input  logic                pcie_cmd_full_n
);

  dma_job_if   job_if ();
  dma_split_if split_if ();

  dma_cmd_fetch u_fetch (
    .pcie_user_clk    (pcie_user_clk),
    .pcie_user_rst_n  (pcie_user_rst_n),
    .dma_cmd_empty_n  (dma_cmd_empty_n),
    .dma_cmd_rd_data  (dma_cmd_rd_data),
    .dma_cmd_rd_en    (dma_cmd_rd_en),
    .hcmd_prp_rd_addr (hcmd_prp_rd_addr),
    .hcmd_prp_rd_data (hcmd_prp_rd_data),
    .job              (job_if.src)
  );

  dma_len_calc u_len_calc (
    .pcie_user_clk   (pcie_user_clk),
    .pcie_user_rst_n (pcie_user_rst_n),
    .job             (job_if.dst),
    .split           (split_if.src)
  );

  dma_cmd_emit u_emit (
    .pcie_user_clk     (pcie_user_clk),
    .pcie_user_rst_n   (pcie_user_rst_n),
    .split             (split_if.dst),
    .dev_rx_cmd_wr_en  (dev_rx_cmd_wr_en),
    .dev_tx_cmd_wr_en  (dev_tx_cmd_wr_en),
    .dev_cmd_wr_data   (dev_cmd_wr_data),
    .dev_rx_cmd_full_n (dev_rx_cmd_full_n),
    .dev_tx_cmd_full_n (dev_tx_cmd_full_n),
    .pcie_cmd_wr_en    (pcie_cmd_wr_en),
    .pcie_cmd_wr_data  (pcie_cmd_wr_data),
    .pcie_cmd_full_n   (pcie_cmd_full_n)
  );

endmodule

//--- logic/dma_cmd_emit.sv
`timescale 1ns/1ns

module dma_cmd_emit
  import dma_cmd_pkg::*;
(
  input  logic           pcie_user_clk,
  input  logic           pcie_user_rst_n,
  dma_split_if.dst       split,
  output logic           dev_rx_cmd_wr_en,
  output logic           dev_tx_cmd_wr_en,
  output dev_cmd_word_t  dev_cmd_wr_data,
  input  logic           dev_rx_cmd_full_n,
  input  logic           dev_tx_cmd_full_n,
  output logic           pcie_cmd_wr_en,
  output pcie_cmd_word_t pcie_cmd_wr_data,
  input  logic           pcie_cmd_full_n
);

  emit_state_t state;
  emit_state_t next_state;
  slot_tag_t   slot_tag;
  logic        dir;
  logic        cmd_type;
  logic        auto_cpl;
  logic        second_valid;
  dev_addr_t   dev_addr;
  dw_len_t     len1;
  dw_len_t     len2;
  host_addr_t  host_addr1;
  host_addr_t  host_addr2;
  logic        dev_full_n;
  logic        both_full_n;
  logic        dev_wr;
  logic        pcie_wr;

  assign dev_full_n  = dir ? dev_tx_cmd_full_n : dev_rx_cmd_full_n;
  assign both_full_n = dev_full_n && pcie_cmd_full_n;
  assign split.ready = (state == ES_IDLE);

  always_ff @(posedge pcie_user_clk or negedge pcie_user_rst_n) begin
    if (!pcie_user_rst_n) begin
      state <= ES_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // each write state also holds while its fifo is full
  always_comb begin
    next_state = state;
    case (state)
      ES_IDLE:      if (split.valid) next_state = ES_CHECK;
      ES_CHECK:     if (both_full_n) next_state = ES_CMD0;
      ES_CMD0:      if (both_full_n) next_state = ES_CMD1;
      ES_CMD1:      if (both_full_n) next_state = ES_CMD2;
      ES_CMD2:      if (pcie_cmd_full_n) next_state = ES_CMD3;
      ES_CMD3:      if (pcie_cmd_full_n) next_state = second_valid ? ES_CHECK_DEV : ES_IDLE;
      ES_CHECK_DEV: if (dev_full_n) next_state = ES_DEV2;
      ES_DEV2:      if (dev_full_n) next_state = ES_DEV3;
      ES_DEV3:      if (dev_full_n) next_state = ES_IDLE;
      default:      next_state = ES_IDLE;
    endcase
  end

  always_ff @(posedge pcie_user_clk) begin
    if (split.valid && split.ready) begin
      slot_tag     <= split.slot_tag;
      dir          <= split.dir;
      cmd_type     <= split.cmd_type;
      auto_cpl     <= split.auto_cpl;
      second_valid <= split.second_valid;
      dev_addr     <= split.dev_addr;
      len1         <= split.len1;
      len2         <= split.len2;
      host_addr1   <= split.host_addr1;
      host_addr2   <= split.host_addr2;
    end
  end

  assign dev_wr  = ((state == ES_CMD0 || state == ES_CMD1) && both_full_n) ||
                   ((state == ES_DEV2 || state == ES_DEV3) && dev_full_n);
  assign pcie_wr = ((state == ES_CMD0 || state == ES_CMD1) && both_full_n) ||
                   ((state == ES_CMD2 || state == ES_CMD3) && pcie_cmd_full_n);

  assign dev_rx_cmd_wr_en = dev_wr && !dir;
  assign dev_tx_cmd_wr_en = dev_wr && dir;
  assign pcie_cmd_wr_en   = pcie_wr;

  always_comb begin
    case (state)
      ES_CMD0: begin
        dev_cmd_wr_data = {{DEV_PAD_W{1'b0}}, auto_cpl, cmd_type, !second_valid,
                           slot_tag, len1}; // last unless split
      end
      ES_CMD1: dev_cmd_wr_data = dev_addr;
      ES_DEV2: dev_cmd_wr_data = {{DEV_PAD_W{1'b0}}, auto_cpl, cmd_type, 1'b1, slot_tag, len2};
      ES_DEV3: dev_cmd_wr_data = dev_addr + dev_addr_t'(len1);
      default: dev_cmd_wr_data = '0;
    endcase
  end

  always_comb begin
    case (state)
      ES_CMD0: pcie_cmd_wr_data = pcie_cmd_word_t'({auto_cpl, cmd_type, dir, second_valid,
                                                    slot_tag});
      ES_CMD1: pcie_cmd_wr_data = pcie_cmd_word_t'({len1, len2});
      ES_CMD2: pcie_cmd_wr_data = host_addr1;
      ES_CMD3: pcie_cmd_wr_data = host_addr2;
      default: pcie_cmd_wr_data = '0;
    endcase
  end

  a_no_wr_when_full: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
    (dev_rx_cmd_wr_en -> dev_rx_cmd_full_n) && (dev_tx_cmd_wr_en -> dev_tx_cmd_full_n) &&
    (pcie_cmd_wr_en -> pcie_cmd_full_n));

  // one command never feeds both device fifos
  a_rx_tx_exclusive: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
    !(dev_rx_cmd_wr_en && dev_tx_cmd_wr_en));

endmodule

//--- logic/dma_len_calc.sv
`timescale 1ns/1ns

module dma_len_calc
  import dma_cmd_pkg::*;
(
  input  logic     pcie_user_clk,
  input  logic     pcie_user_rst_n,
  dma_job_if.dst   job,
  dma_split_if.src split
);

  logic                                           accept;
  logic                                           is_prp;
  logic [$bits(page_idx_t)+$bits(page_off_t)-1:0] page_sum;
  page_idx_t                                      page_n;
  page_off_t                                      page_o;
  host_addr_t                                     prp1_base;
  host_addr_t                                     prp2_base;

  assign job.ready = !split.valid || split.ready; // empty or draining
  assign accept    = job.valid && job.ready;
  assign is_prp    = !job.cmd_type;

  // page index in 4 KB units plus the dword offset of prp1
  assign page_sum         = {job.page_idx, page_off_t'(0)} + page_off_t'(job.prp1);
  assign {page_n, page_o} = page_sum;

  assign prp1_base = job.prp1 & ~host_addr_t'(PAGE_DW - 1);
  assign prp2_base = job.prp2 & ~host_addr_t'(PAGE_DW - 1);

  always_ff @(posedge pcie_user_clk or negedge pcie_user_rst_n) begin
    if (!pcie_user_rst_n) begin
      split.valid <= 1'b0;
    end else if (accept) begin
      split.valid <= 1'b1;
    end else if (split.ready) begin
      split.valid <= 1'b0;
    end
  end

  always_ff @(posedge pcie_user_clk) begin
    if (accept) begin
      split.slot_tag <= job.slot_tag;
      split.dir      <= job.dir;
      split.cmd_type <= job.cmd_type;
      split.auto_cpl <= job.auto_cpl;
      if (is_prp) begin
        split.dev_addr     <= job.dev_addr & ~dev_addr_t'(PAGE_DW - 1); // page aligned
        split.len1         <= dw_len_t'(PAGE_DW) - dw_len_t'(page_o);
        split.len2         <= dw_len_t'(page_o);
        split.second_valid <= (page_o != '0);
        split.host_addr1   <= ((page_n == '0) ? prp1_base : prp2_base) | host_addr_t'(page_o);
        split.host_addr2   <= prp2_base;
      end else begin
        split.dev_addr     <= job.dev_addr;
        split.len1         <= job.dev_len;
        split.len2         <= '0;
        split.second_valid <= 1'b0;
        split.host_addr1   <= job.prp1;
        split.host_addr2   <= '0;
      end
    end
  end

  // beyond prp2 the data pointer would come from a prp list
  a_prp_no_list: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
    accept && is_prp |-> (page_n == '0) || (page_n == 1 && page_o == '0));

endmodule

//--- logic/dma_cmd_fetch.sv
`timescale 1ns/1ns

module dma_cmd_fetch
  import dma_cmd_pkg::*;
(
  input  logic                pcie_user_clk,
  input  logic                pcie_user_rst_n,
  input  logic                dma_cmd_empty_n,
  input  dma_cmd_word_t       dma_cmd_rd_data,
  output logic                dma_cmd_rd_en,
  output logic [SLOT_TAG_W:0] hcmd_prp_rd_addr,
  input  prp_word_t           hcmd_prp_rd_data,
  dma_job_if.src              job
);

  fetch_state_t state;
  fetch_state_t next_state;

  always_ff @(posedge pcie_user_clk or negedge pcie_user_rst_n) begin
    if (!pcie_user_rst_n) begin
      state <= FS_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      FS_IDLE:   if (dma_cmd_empty_n) next_state = FS_CMD0;
      FS_CMD0:   next_state = FS_CMD1;
      FS_CMD1:   next_state = job.cmd_type ? FS_VALID : FS_PRP_A1;
      FS_PRP_A1: next_state = FS_PRP_A2;
      FS_PRP_A2: next_state = FS_PRP_D2;
      FS_PRP_D2: next_state = FS_VALID;
      FS_VALID:  if (job.ready) next_state = FS_IDLE;
      default:   next_state = FS_IDLE;
    endcase
  end

  // decode both words, then overwrite prp1 from the table on prp commands
  always_ff @(posedge pcie_user_clk) begin
    case (state)
      FS_CMD0: begin
        job.dev_addr <= dma_cmd_rd_data[$bits(dev_addr_t)-1:0];
        job.dev_len  <= dma_cmd_rd_data[F_DEV_LEN_LSB +: $bits(dw_len_t)];
        job.slot_tag <= dma_cmd_rd_data[F_SLOT_LSB +: SLOT_TAG_W];
        job.dir      <= dma_cmd_rd_data[F_DIR_BIT];
        job.cmd_type <= dma_cmd_rd_data[F_TYPE_BIT];
      end
      FS_CMD1: begin
        job.prp1     <= dma_cmd_rd_data[$bits(host_addr_t)-1:0]; // host addr on direct
        job.page_idx <= dma_cmd_rd_data[F_OFFSET_LSB +: $bits(page_idx_t)];
        job.auto_cpl <= dma_cmd_rd_data[F_AUTO_CPL_BIT];
      end
      FS_PRP_A2: begin
        job.prp1 <= hcmd_prp_rd_data[$bits(host_addr_t)-1:0];
      end
      FS_PRP_D2: begin
        job.prp2 <= hcmd_prp_rd_data[$bits(host_addr_t)-1:0];
      end
      default: begin
      end
    endcase
  end

  assign dma_cmd_rd_en    = (state == FS_CMD0) || (state == FS_CMD1);
  assign hcmd_prp_rd_addr = {job.slot_tag, state == FS_PRP_A2}; // low bit picks prp2
  assign job.valid        = (state == FS_VALID);

  // a pair is popped only once the fifo has announced it
  a_pop_needs_pair: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
    $rose(dma_cmd_rd_en) |-> dma_cmd_empty_n);

endmodule

//--- logic/dma_split_if.sv
`timescale 1ns/1ns

interface dma_split_if
  import dma_cmd_pkg::*;
();

  logic       valid;
  logic       ready;
  slot_tag_t  slot_tag;
  logic       dir;
  logic       cmd_type;
  logic       auto_cpl;
  dev_addr_t  dev_addr;
  dw_len_t    len1;
  dw_len_t    len2;
  logic       second_valid; // crosses a host page
  host_addr_t host_addr1;
  host_addr_t host_addr2;

  modport src (
    output valid, slot_tag, dir, cmd_type, auto_cpl, dev_addr,
    output len1, len2, second_valid, host_addr1, host_addr2,
    input  ready
  );

  modport dst (
    input  valid, slot_tag, dir, cmd_type, auto_cpl, dev_addr,
    input  len1, len2, second_valid, host_addr1, host_addr2,
    output ready
  );

endinterface

//--- logic/dma_job_if.sv
`timescale 1ns/1ns

interface dma_job_if
  import dma_cmd_pkg::*;
();

  logic       valid;
  logic       ready;
  slot_tag_t  slot_tag;
  logic       dir;      // 1 is tx
  logic       cmd_type; // 1 is direct, 0 is prp
  logic       auto_cpl;
  dev_addr_t  dev_addr;
  dw_len_t    dev_len;
  page_idx_t  page_idx;
  host_addr_t prp1;
  host_addr_t prp2;

  modport src (
    output valid, slot_tag, dir, cmd_type, auto_cpl,
    output dev_addr, dev_len, page_idx, prp1, prp2,
    input  ready
  );

  modport dst (
    input  valid, slot_tag, dir, cmd_type, auto_cpl,
    input  dev_addr, dev_len, page_idx, prp1, prp2,
    output ready
  );

endinterface

//--- logic/dma_cmd_pkg.sv
package dma_cmd_pkg;

  localparam int SLOT_TAG_W  = 10;
  localparam int HOST_ADDR_W = 48;   // byte address
  localparam int PAGE_DW     = 1024; // dwords in a 4 KB page
  localparam int DEV_PAD_W   = 6;

  // command word 0
  localparam int F_DEV_LEN_LSB  = 30;
  localparam int F_SLOT_LSB     = 41;
  localparam int F_DIR_BIT      = 51;
  localparam int F_TYPE_BIT     = 52;
  // command word 1
  localparam int F_OFFSET_LSB   = 46; // 4 KB page index
  localparam int F_AUTO_CPL_BIT = 55;

  typedef logic [SLOT_TAG_W-1:0]  slot_tag_t;
  typedef logic [29:0]            dev_addr_t;      // byte bits 31:2
  typedef logic [10:0]            dw_len_t;        // up to 1024
  typedef logic [9:0]             page_off_t;
  typedef logic [8:0]             page_idx_t;
  typedef logic [HOST_ADDR_W-3:0] host_addr_t;     // dword address
  typedef logic [55:0]            dma_cmd_word_t;
  typedef logic [53:0]            prp_word_t;      // prp in 45:0
  typedef logic [29:0]            dev_cmd_word_t;
  typedef logic [45:0]            pcie_cmd_word_t;

  typedef enum logic [2:0] {
    FS_IDLE,
    FS_CMD0,   // pop word 0
    FS_CMD1,   // pop word 1
    FS_PRP_A1, // prp1 address out
    FS_PRP_A2, // prp2 address out, prp1 data in
    FS_PRP_D2, // prp2 data in
    FS_VALID
  } fetch_state_t;

  typedef enum logic [3:0] {
    ES_IDLE,
    ES_CHECK,
    ES_CMD0,
    ES_CMD1,
    ES_CMD2,
    ES_CMD3,
    ES_CHECK_DEV,
    ES_DEV2,
    ES_DEV3
  } emit_state_t;

endpackage
